//--- verilog/isa_pkg.sv
package isa_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] inst_t;
    typedef logic [4:0] reg_addr_t;
    typedef logic [6:0] opcode_t;
    typedef logic [2:0] funct3_t;

    // Base opcodes kept by this core
    localparam opcode_t OPC_OP     = 7'b0110011;
    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_AUIPC  = 7'b0010111;
    localparam opcode_t OPC_JAL    = 7'b1101111;
    localparam opcode_t OPC_BRANCH = 7'b1100011;

    // Branch conditions in funct3
    localparam funct3_t BR_EQ  = 3'b000;
    localparam funct3_t BR_NE  = 3'b001;
    localparam funct3_t BR_LT  = 3'b100;
    localparam funct3_t BR_GE  = 3'b101;
    localparam funct3_t BR_LTU = 3'b110;
    localparam funct3_t BR_GEU = 3'b111;

    // addi x0, x0, 0
    localparam inst_t NOP_INST = 32'h0000_0013;

    function automatic word_t imm_i(inst_t inst);
        return {{20{inst[31]}}, inst[31:20]};
    endfunction

    function automatic word_t imm_u(inst_t inst);
        return {inst[31:12], 12'b0};
    endfunction

    function automatic word_t imm_b(inst_t inst);
        return {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    endfunction

    function automatic word_t imm_j(inst_t inst);
        return {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
    endfunction

endpackage

//--- verilog/core_pkg.sv
package core_pkg;

    localparam isa_pkg::word_t RESET_PC = 32'h0000_0000;

    // Instruction memory, word addressed
    localparam int IMEM_DEPTH = 256;
    typedef logic [$clog2(IMEM_DEPTH)-1:0] imem_addr_t;

    // Branch history table, indexed by PC[7:2]
    localparam int BHT_ENTRIES = 64;
    typedef logic [$clog2(BHT_ENTRIES)-1:0] bht_index_t;

    // Commit port credits
    localparam int COMMIT_CREDITS = 4;
    typedef logic [$clog2(COMMIT_CREDITS+1)-1:0] credit_t;

    typedef logic [3:0] alu_op_t;
    localparam alu_op_t ALU_ADD  = 4'd0;
    localparam alu_op_t ALU_SUB  = 4'd1;
    localparam alu_op_t ALU_SLL  = 4'd2;
    localparam alu_op_t ALU_SLT  = 4'd3;
    localparam alu_op_t ALU_SLTU = 4'd4;
    localparam alu_op_t ALU_XOR  = 4'd5;
    localparam alu_op_t ALU_SRL  = 4'd6;
    localparam alu_op_t ALU_SRA  = 4'd7;
    localparam alu_op_t ALU_OR   = 4'd8;
    localparam alu_op_t ALU_AND  = 4'd9;

    typedef enum logic [1:0] {STRONG_NT, WEAK_NT, WEAK_T, STRONG_T} bp_state_t;

endpackage

//--- verilog/alu.sv
`timescale 1ns/100ps

module alu (
    input  core_pkg::alu_op_t alu_op,
    input  isa_pkg::word_t    a,
    input  isa_pkg::word_t    b,
    output isa_pkg::word_t    result
);
    import core_pkg::*;

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (alu_op)
            ALU_ADD:  result = a + b;
            ALU_SUB:  result = a - b;
            ALU_SLL:  result = a << shamt;
            ALU_SLT:  result = {31'b0, $signed(a) < $signed(b)};
            ALU_SLTU: result = {31'b0, a < b};
            ALU_XOR:  result = a ^ b;
            ALU_SRL:  result = a >> shamt;
            ALU_SRA:  result = $signed(a) >>> shamt;
            ALU_OR:   result = a | b;
            ALU_AND:  result = a & b;
            default:  result = '0;
        endcase
    end

endmodule

//--- verilog/reg_file.sv
`timescale 1ns/100ps

module reg_file (
    input  logic               clk,
    input  isa_pkg::reg_addr_t ra1,
    input  isa_pkg::reg_addr_t ra2,
    output isa_pkg::word_t     rd1,
    output isa_pkg::word_t     rd2,
    input  logic               we,
    input  isa_pkg::reg_addr_t wa,
    input  isa_pkg::word_t     wd
);
    import isa_pkg::*;

    word_t regs [32];

    // x0 is never written and always reads zero
    always_ff @(posedge clk) begin
        if (we && wa != '0) begin
            regs[wa] <= wd;
        end
    end

    assign rd1 = (ra1 == '0) ? '0 : regs[ra1];
    assign rd2 = (ra2 == '0) ? '0 : regs[ra2];

endmodule

//--- verilog/branch_predictor.sv
`timescale 1ns/100ps

module branch_predictor (
    input  logic           clk,
    input  logic           reset,
    input  isa_pkg::word_t lookup_pc,
    output logic           pred_taken,
    input  logic           bp_update,
    input  isa_pkg::word_t update_pc,
    input  logic           update_taken
);
    import core_pkg::*;

    bp_state_t  bht [BHT_ENTRIES];
    bp_state_t  upd_next;
    bht_index_t lookup_idx;
    bht_index_t update_idx;

    assign lookup_idx = lookup_pc[$bits(bht_index_t)+1:2];
    assign update_idx = update_pc[$bits(bht_index_t)+1:2];

    assign pred_taken = bht[lookup_idx] == WEAK_T || bht[lookup_idx] == STRONG_T;

    // Saturate toward the resolved outcome
    always_comb begin
        case (bht[update_idx])
            STRONG_NT: upd_next = update_taken ? WEAK_NT : STRONG_NT;
            WEAK_NT:   upd_next = update_taken ? WEAK_T : STRONG_NT;
            WEAK_T:    upd_next = update_taken ? STRONG_T : WEAK_NT;
            default:   upd_next = update_taken ? STRONG_T : WEAK_T;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < BHT_ENTRIES; i++) begin
                bht[i] <= WEAK_NT;
            end
        end else if (bp_update) begin
            bht[update_idx] <= upd_next;
        end
    end

endmodule

//--- verilog/fetch_unit.sv
`timescale 1ns/100ps

module fetch_unit (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 run,
    input  logic                 bp_enable,
    input  logic                 load_en,
    input  core_pkg::imem_addr_t load_addr,
    input  isa_pkg::word_t       load_data,
    input  logic                 stall,
    input  logic                 redirect,
    input  isa_pkg::word_t       redirect_pc,
    input  logic                 bp_update,
    input  isa_pkg::word_t       bp_update_pc,
    input  logic                 bp_update_taken,
    output isa_pkg::inst_t       f_inst,
    output isa_pkg::word_t       f_pc,
    output logic                 f_pred_taken
);
    import isa_pkg::*;
    import core_pkg::*;

    inst_t      imem [IMEM_DEPTH];
    inst_t      imem_q;
    word_t      pc;
    word_t      next_pc;
    imem_addr_t rd_addr;
    logic       bp_pred;
    logic       is_jal;
    logic       is_branch;

    branch_predictor u_bp (
        .clk(clk), .reset(reset),
        .lookup_pc(pc), .pred_taken(bp_pred),
        .bp_update(bp_update), .update_pc(bp_update_pc), .update_taken(bp_update_taken)
    );

    // Memory output is only meaningful once the core is running
    assign f_inst = run ? imem_q : NOP_INST;
    assign f_pc = pc;

    assign is_jal = f_inst[6:0] == OPC_JAL;
    assign is_branch = f_inst[6:0] == OPC_BRANCH;
    assign f_pred_taken = is_branch && bp_enable && bp_pred;

    always_comb begin
        if (reset || !run) next_pc = RESET_PC;
        else if (redirect) next_pc = redirect_pc;
        else if (stall) next_pc = pc;
        else if (is_jal) next_pc = pc + imm_j(f_inst);
        else if (f_pred_taken) next_pc = pc + imm_b(f_inst);
        else next_pc = pc + 32'd4;
    end

    // Memory is read with the next PC so its output lines up with pc
    assign rd_addr = next_pc[$bits(imem_addr_t)+1:2];

    // Reset reaches pc through next_pc
    always_ff @(posedge clk) begin
        pc <= next_pc;
        imem_q <= imem[rd_addr];
        if (load_en) begin
            imem[load_addr] <= load_data;
        end
    end

endmodule

//--- verilog/decode_unit.sv
`timescale 1ns/100ps

module decode_unit (
    input  logic               clk,
    input  logic               reset,
    input  logic               stall,
    input  logic               redirect,
    input  isa_pkg::inst_t     f_inst,
    input  isa_pkg::word_t     f_pc,
    input  logic               f_pred_taken,
    input  logic               x_wr_en,
    input  isa_pkg::reg_addr_t x_rd,
    input  isa_pkg::word_t     x_result,
    input  logic               wb_valid,
    input  isa_pkg::reg_addr_t wb_rd,
    input  isa_pkg::word_t     wb_data,
    output isa_pkg::word_t     d_pc,
    output isa_pkg::word_t     d_op_a,
    output isa_pkg::word_t     d_op_b,
    output isa_pkg::word_t     d_imm,
    output core_pkg::alu_op_t  d_alu_op,
    output isa_pkg::reg_addr_t d_rd,
    output logic               d_wr_en,
    output logic               d_is_branch,
    output isa_pkg::funct3_t   d_funct3,
    output logic               d_pred_taken
);
    import isa_pkg::*;
    import core_pkg::*;

    inst_t     inst_q;
    word_t     pc_q;
    logic      pred_q;
    reg_addr_t rs1;
    reg_addr_t rs2;
    word_t     rf_rd1;
    word_t     rf_rd2;
    word_t     rs1_val;
    word_t     rs2_val;
    logic      writes;

    function automatic alu_op_t f3_to_alu(funct3_t f3, logic alt);
        case (f3)
            3'b000:  return alt ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return alt ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    // Wrong-path fetch is squashed into a NOP on redirect
    always_ff @(posedge clk) begin
        if (reset || redirect) begin
            inst_q <= NOP_INST;
            pred_q <= 1'b0;
        end else if (!stall) begin
            inst_q <= f_inst;
            pred_q <= f_pred_taken;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            pc_q <= f_pc;
        end
    end

    assign rs1 = inst_q[19:15];
    assign rs2 = inst_q[24:20];

    reg_file u_rf (
        .clk(clk), .ra1(rs1), .ra2(rs2), .rd1(rf_rd1), .rd2(rf_rd2),
        .we(wb_valid), .wa(wb_rd), .wd(wb_data)
    );

    // Bypass from the instruction currently in execute
    assign rs1_val = (x_wr_en && rs1 != '0 && x_rd == rs1) ? x_result : rf_rd1;
    assign rs2_val = (x_wr_en && rs2 != '0 && x_rd == rs2) ? x_result : rf_rd2;

    always_comb begin
        d_alu_op = ALU_ADD;
        d_op_a = rs1_val;
        d_op_b = rs2_val;
        d_imm = imm_i(inst_q);
        d_is_branch = 1'b0;
        writes = 1'b0;
        case (inst_q[6:0])
            OPC_OP: begin
                d_alu_op = f3_to_alu(inst_q[14:12], inst_q[30]);
                writes = 1'b1;
            end
            OPC_OP_IMM: begin
                // Only the shift-right form uses bit 30 as a modifier
                d_alu_op = f3_to_alu(inst_q[14:12], inst_q[30] && inst_q[14:12] == 3'b101);
                d_op_b = imm_i(inst_q);
                writes = 1'b1;
            end
            OPC_LUI: begin
                d_imm = imm_u(inst_q);
                d_op_a = '0;
                d_op_b = imm_u(inst_q);
                writes = 1'b1;
            end
            OPC_AUIPC: begin
                d_imm = imm_u(inst_q);
                d_op_a = pc_q;
                d_op_b = imm_u(inst_q);
                writes = 1'b1;
            end
            OPC_JAL: begin
                // Link value is PC plus 4
                d_imm = imm_j(inst_q);
                d_op_a = pc_q;
                d_op_b = 32'd4;
                writes = 1'b1;
            end
            OPC_BRANCH: begin
                d_imm = imm_b(inst_q);
                d_is_branch = 1'b1;
            end
            default: begin
                writes = 1'b0;
            end
        endcase
    end

    assign d_rd = inst_q[11:7];
    assign d_wr_en = writes && d_rd != '0;
    assign d_funct3 = inst_q[14:12];
    assign d_pc = pc_q;
    assign d_pred_taken = pred_q;

endmodule

//--- verilog/execute_unit.sv
`timescale 1ns/100ps

module execute_unit (
    input  logic               clk,
    input  logic               reset,
    input  isa_pkg::word_t     d_pc,
    input  isa_pkg::word_t     d_op_a,
    input  isa_pkg::word_t     d_op_b,
    input  isa_pkg::word_t     d_imm,
    input  core_pkg::alu_op_t  d_alu_op,
    input  isa_pkg::reg_addr_t d_rd,
    input  logic               d_wr_en,
    input  logic               d_is_branch,
    input  isa_pkg::funct3_t   d_funct3,
    input  logic               d_pred_taken,
    input  logic               wb_credit,
    output logic               wb_valid,
    output isa_pkg::word_t     wb_pc,
    output isa_pkg::reg_addr_t wb_rd,
    output isa_pkg::word_t     wb_data,
    output logic               stall,
    output logic               redirect,
    output isa_pkg::word_t     redirect_pc,
    output logic               bp_update,
    output isa_pkg::word_t     bp_update_pc,
    output logic               bp_update_taken,
    output logic               x_wr_en,
    output isa_pkg::reg_addr_t x_rd,
    output isa_pkg::word_t     x_result
);
    import isa_pkg::*;
    import core_pkg::*;

    word_t     ex_pc;
    word_t     ex_op_a;
    word_t     ex_op_b;
    word_t     ex_imm;
    alu_op_t   ex_alu_op;
    reg_addr_t ex_rd;
    logic      ex_wr_en;
    logic      ex_is_branch;
    funct3_t   ex_funct3;
    logic      ex_pred_taken;
    word_t     alu_result;
    logic      taken;
    credit_t   credits;

    // A redirect leaves a bubble behind the resolving branch
    always_ff @(posedge clk) begin
        if (reset || redirect) begin
            ex_wr_en <= 1'b0;
            ex_is_branch <= 1'b0;
        end else if (!stall) begin
            ex_wr_en <= d_wr_en;
            ex_is_branch <= d_is_branch;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            ex_pc <= d_pc;
            ex_op_a <= d_op_a;
            ex_op_b <= d_op_b;
            ex_imm <= d_imm;
            ex_alu_op <= d_alu_op;
            ex_rd <= d_rd;
            ex_funct3 <= d_funct3;
            ex_pred_taken <= d_pred_taken;
        end
    end

    alu u_alu (.alu_op(ex_alu_op), .a(ex_op_a), .b(ex_op_b), .result(alu_result));

    always_comb begin
        case (ex_funct3)
            BR_EQ:   taken = ex_op_a == ex_op_b;
            BR_NE:   taken = ex_op_a != ex_op_b;
            BR_LT:   taken = $signed(ex_op_a) < $signed(ex_op_b);
            BR_GE:   taken = $signed(ex_op_a) >= $signed(ex_op_b);
            BR_LTU:  taken = ex_op_a < ex_op_b;
            BR_GEU:  taken = ex_op_a >= ex_op_b;
            default: taken = 1'b0;
        endcase
    end

    // Mispredict in either direction
    assign redirect = ex_is_branch && (taken != ex_pred_taken);
    assign redirect_pc = taken ? ex_pc + ex_imm : ex_pc + 32'd4;

    assign bp_update = ex_is_branch;
    assign bp_update_pc = ex_pc;
    assign bp_update_taken = taken;

    // Commit only while the receiver has room
    assign wb_valid = ex_wr_en && credits != '0;
    assign stall = ex_wr_en && credits == '0;
    assign wb_pc = ex_pc;
    assign wb_rd = ex_rd;
    assign wb_data = alu_result;

    assign x_wr_en = ex_wr_en;
    assign x_rd = ex_rd;
    assign x_result = alu_result;

    always_ff @(posedge clk) begin
        if (reset) begin
            credits <= credit_t'(COMMIT_CREDITS);
        end else if (wb_valid && !wb_credit) begin
            credits <= credits - credit_t'(1);
        end else if (!wb_valid && wb_credit) begin
            credits <= credits + credit_t'(1);
        end
    end

endmodule

//--- verilog/cpu.sv
`timescale 1ns/100ps

module cpu (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 run,
    input  logic                 bp_enable,
    input  logic                 load_en,
    input  core_pkg::imem_addr_t load_addr,
    input  isa_pkg::word_t       load_data,
    input  logic                 wb_credit,
    output logic                 wb_valid,
    output isa_pkg::word_t       wb_pc,
    output isa_pkg::reg_addr_t   wb_rd,
    output isa_pkg::word_t       wb_data
);
    import isa_pkg::*;
    import core_pkg::*;

    // Fetch to decode
    inst_t     f_inst;
    word_t     f_pc;
    logic      f_pred_taken;

    // Decode to execute
    word_t     d_pc;
    word_t     d_op_a;
    word_t     d_op_b;
    word_t     d_imm;
    alu_op_t   d_alu_op;
    reg_addr_t d_rd;
    logic      d_wr_en;
    logic      d_is_branch;
    funct3_t   d_funct3;
    logic      d_pred_taken;

    // Execute feedback
    logic      x_wr_en;
    reg_addr_t x_rd;
    word_t     x_result;
    logic      stall;
    logic      redirect;
    word_t     redirect_pc;
    logic      bp_update;
    word_t     bp_update_pc;
    logic      bp_update_taken;

    fetch_unit u_fetch (
        .clk(clk), .reset(reset), .run(run), .bp_enable(bp_enable),
        .load_en(load_en), .load_addr(load_addr), .load_data(load_data),
        .stall(stall), .redirect(redirect), .redirect_pc(redirect_pc),
        .bp_update(bp_update), .bp_update_pc(bp_update_pc),
        .bp_update_taken(bp_update_taken),
        .f_inst(f_inst), .f_pc(f_pc), .f_pred_taken(f_pred_taken)
    );

    decode_unit u_decode (
        .clk(clk), .reset(reset), .stall(stall), .redirect(redirect),
        .f_inst(f_inst), .f_pc(f_pc), .f_pred_taken(f_pred_taken),
        .x_wr_en(x_wr_en), .x_rd(x_rd), .x_result(x_result),
        .wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data),
        .d_pc(d_pc), .d_op_a(d_op_a), .d_op_b(d_op_b), .d_imm(d_imm),
        .d_alu_op(d_alu_op), .d_rd(d_rd), .d_wr_en(d_wr_en),
        .d_is_branch(d_is_branch), .d_funct3(d_funct3), .d_pred_taken(d_pred_taken)
    );

    execute_unit u_execute (
        .clk(clk), .reset(reset),
        .d_pc(d_pc), .d_op_a(d_op_a), .d_op_b(d_op_b), .d_imm(d_imm),
        .d_alu_op(d_alu_op), .d_rd(d_rd), .d_wr_en(d_wr_en),
        .d_is_branch(d_is_branch), .d_funct3(d_funct3), .d_pred_taken(d_pred_taken),
        .wb_credit(wb_credit),
        .wb_valid(wb_valid), .wb_pc(wb_pc), .wb_rd(wb_rd), .wb_data(wb_data),
        .stall(stall), .redirect(redirect), .redirect_pc(redirect_pc),
        .bp_update(bp_update), .bp_update_pc(bp_update_pc),
        .bp_update_taken(bp_update_taken),
        .x_wr_en(x_wr_en), .x_rd(x_rd), .x_result(x_result)
    );

endmodule

//--- tb/cpu_sva.sv
`timescale 1ns/100ps

module cpu_sva (
    input  logic              clk,
    input  logic              reset,
    input  logic              wb_valid,
    input  isa_pkg::word_t    wb_pc,
    input  logic              wb_credit,
    input  logic              stall,
    input  logic              redirect,
    input  core_pkg::credit_t credits
);
    import core_pkg::*;

    int commits_seen;
    int credits_back;

    // Commits and returned credits since reset
    always_ff @(posedge clk) begin
        if (reset) begin
            commits_seen <= 0;
            credits_back <= 0;
        end else begin
            if (wb_valid) begin
                commits_seen <= commits_seen + 1;
            end
            if (wb_credit) begin
                credits_back <= credits_back + 1;
            end
        end
    end

    // No commit into an empty credit pool
    a_valid_needs_credit: assert property (
        @(posedge clk) disable iff (reset)
        wb_valid |-> commits_seen - credits_back < COMMIT_CREDITS
    ) else $error("wb_valid high with no credit outstanding at the receiver");

    a_valid_low_after_reset: assert property (
        @(posedge clk) reset |=> !wb_valid
    ) else $error("wb_valid high right after reset");

    // Returned credits never exceed the pool size
    a_credit_bound: assert property (
        @(posedge clk) disable iff (reset) credits <= credit_t'(COMMIT_CREDITS)
    ) else $error("credit count above the pool size");

    // A stalled commit is held until it goes out
    a_stall_holds_commit: assert property (
        @(posedge clk) disable iff (reset)
        stall |=> (stall || wb_valid) && $stable(wb_pc)
    ) else $error("stalled commit dropped or changed");

    a_no_redirect_in_stall: assert property (
        @(posedge clk) disable iff (reset) !(stall && redirect)
    ) else $error("redirect and stall in the same cycle");

endmodule

bind execute_unit cpu_sva u_sva (
    .clk(clk),
    .reset(reset),
    .wb_valid(wb_valid),
    .wb_pc(wb_pc),
    .wb_credit(wb_credit),
    .stall(stall),
    .redirect(redirect),
    .credits(credits)
);

//--- tb/tb_cpu.sv
`timescale 1ns/100ps

module tb_cpu;
    import isa_pkg::*;
    import core_pkg::*;

    localparam int PROG_LEN = 60;
    localparam int LAST_IDX = PROG_LEN - 1;
    localparam int TIMEOUT_CYCLES = PROG_LEN * (3 + 7) * 2 + 200;
    localparam int IDLE_CYCLES = 50;

    typedef enum int {K_OP, K_OPI, K_LUI, K_AUIPC, K_JAL, K_BR} kind_t;

    logic       clk;
    logic       reset;
    logic       run;
    logic       bp_enable;
    logic       load_en;
    imem_addr_t load_addr;
    word_t      load_data;
    logic       wb_credit = 1'b0;
    logic       wb_valid;
    word_t      wb_pc;
    reg_addr_t  wb_rd;
    word_t      wb_data;

    // Instruction fields for the reference model
    kind_t     p_kind [PROG_LEN];
    funct3_t   p_f3 [PROG_LEN];
    logic      p_alt [PROG_LEN];
    reg_addr_t p_rd [PROG_LEN];
    reg_addr_t p_rs1 [PROG_LEN];
    reg_addr_t p_rs2 [PROG_LEN];
    word_t     p_imm [PROG_LEN];
    inst_t     prog [PROG_LEN];

    // Expected commit list
    word_t     exp_pc [$];
    reg_addr_t exp_rd [$];
    word_t     exp_val [$];

    int cycle = 0;
    int commit_count = 0;
    int commit_base = 0;
    int run_start_cycle = 0;
    int error_count = 0;
    int last_due = 0;
    int credit_due [$];

    cpu dut (
        .clk(clk), .reset(reset), .run(run), .bp_enable(bp_enable),
        .load_en(load_en), .load_addr(load_addr), .load_data(load_data),
        .wb_credit(wb_credit), .wb_valid(wb_valid), .wb_pc(wb_pc),
        .wb_rd(wb_rd), .wb_data(wb_data)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic reg_addr_t pick_reg();
        // Only x0..x7 so dependent pairs are frequent
        return reg_addr_t'($urandom % 8);
    endfunction

    function automatic int jump_offset(input int i);
        int span;
        span = (LAST_IDX - i < 4) ? LAST_IDX - i : 4;
        return 4 * (1 + int'($urandom % span));
    endfunction

    function automatic funct3_t pick_branch_cond();
        case ($urandom % 6)
            0:       return 3'b000;
            1:       return 3'b001;
            2:       return 3'b100;
            3:       return 3'b101;
            4:       return 3'b110;
            default: return 3'b111;
        endcase
    endfunction

    function automatic inst_t encode_inst(input int i);
        word_t m;
        m = p_imm[i];
        case (p_kind[i])
            K_OP:    return {1'b0, p_alt[i], 5'b0, p_rs2[i], p_rs1[i], p_f3[i], p_rd[i], OPC_OP};
            K_OPI:   return {m[11:0], p_rs1[i], p_f3[i], p_rd[i], OPC_OP_IMM};
            K_LUI:   return {m[31:12], p_rd[i], OPC_LUI};
            K_AUIPC: return {m[31:12], p_rd[i], OPC_AUIPC};
            K_JAL:   return {m[20], m[10:1], m[11], m[19:12], p_rd[i], OPC_JAL};
            default: return {m[12], m[10:5], p_rs2[i], p_rs1[i], p_f3[i], m[4:1], m[11],
                             OPC_BRANCH};
        endcase
    endfunction

    // addi x0, x0, addr for the words past the program
    function automatic word_t fill_word(input int a);
        return {4'b0, a[7:0], 5'd0, 3'b000, 5'd0, OPC_OP_IMM};
    endfunction

    function automatic word_t compute_alu(input funct3_t f3, input logic alt,
                                          input word_t a, input word_t b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011:  return (a < b) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b101: begin
                if (alt) begin
                    return $signed(a) >>> b[4:0];
                end else begin
                    return a >> b[4:0];
                end
            end
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic resolve_branch(input funct3_t f3, input word_t a, input word_t b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            default: return a >= b;
        endcase
    endfunction

    task automatic generate_program();
        word_t r;
        int    i;
        for (i = 0; i < PROG_LEN; i++) begin
            r = $urandom;
            p_rd[i] = pick_reg();
            p_rs1[i] = pick_reg();
            p_rs2[i] = pick_reg();
            p_f3[i] = funct3_t'($urandom % 8);
            p_alt[i] = 1'b0;
            p_imm[i] = {{20{r[11]}}, r[11:0]};
            if (i < 7) begin
                // Seed x1..x7 before any random reads
                p_kind[i] = K_OPI;
                p_f3[i] = 3'b000;
                p_rd[i] = reg_addr_t'(i + 1);
                p_rs1[i] = '0;
            end else if (i == LAST_IDX) begin
                // jal x0, 0 parks the core
                p_kind[i] = K_JAL;
                p_rd[i] = '0;
                p_imm[i] = '0;
            end else begin
                p_kind[i] = kind_t'($urandom % 6);
                case (p_kind[i])
                    K_OP: begin
                        p_alt[i] = (p_f3[i] == 3'b000 || p_f3[i] == 3'b101) && r[12];
                    end
                    K_OPI: begin
                        if (p_f3[i] == 3'b001 || p_f3[i] == 3'b101) begin
                            p_alt[i] = p_f3[i] == 3'b101 && r[12];
                            p_imm[i] = {21'b0, p_alt[i], 5'b0, r[4:0]};
                        end
                    end
                    K_LUI, K_AUIPC: begin
                        p_imm[i] = {r[31:12], 12'b0};
                    end
                    K_JAL: begin
                        p_imm[i] = word_t'(jump_offset(i));
                    end
                    default: begin
                        p_f3[i] = pick_branch_cond();
                        p_imm[i] = word_t'(jump_offset(i));
                    end
                endcase
            end
            prog[i] = encode_inst(i);
        end
    endtask

    // Architectural model stepping one instruction at a time
    task automatic build_expected();
        word_t regs [32];
        word_t pc;
        word_t val;
        int    i;
        int    next;
        logic  writes;
        for (i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        i = 0;
        while (i != LAST_IDX) begin
            pc = word_t'(4 * i);
            next = i + 1;
            writes = 1'b1;
            val = '0;
            case (p_kind[i])
                K_OP:    val = compute_alu(p_f3[i], p_alt[i], regs[p_rs1[i]], regs[p_rs2[i]]);
                K_OPI:   val = compute_alu(p_f3[i], p_alt[i], regs[p_rs1[i]], p_imm[i]);
                K_LUI:   val = p_imm[i];
                K_AUIPC: val = pc + p_imm[i];
                K_JAL: begin
                    val = pc + 32'd4;
                    next = i + int'(p_imm[i] >> 2);
                end
                default: begin
                    writes = 1'b0;
                    if (resolve_branch(p_f3[i], regs[p_rs1[i]], regs[p_rs2[i]])) begin
                        next = i + int'(p_imm[i] >> 2);
                    end
                end
            endcase
            if (writes && p_rd[i] != '0) begin
                regs[p_rd[i]] = val;
                exp_pc.push_back(pc);
                exp_rd.push_back(p_rd[i]);
                exp_val.push_back(val);
            end
            i = next;
        end
    endtask

    task automatic check_value(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            error_count++;
            $display("[FAIL] t=%0t %s: expected 0x%08h, actual 0x%08h",
                     $time, name, expected, actual);
            $display("Simulation failed");
            $fatal(1, "Commit mismatch");
        end
    endtask

    task automatic record_commit();
        int n;
        int due;
        n = commit_count - commit_base;
        if (n >= exp_pc.size()) begin
            $display("Unexpected commit at t=%0t from pc 0x%08h past the end of the list",
                     $time, wb_pc);
            $display("Simulation failed");
            $fatal(1, "Extra commit");
        end else begin
            check_value("wb_pc", exp_pc[n], wb_pc);
            check_value("wb_rd", {27'b0, exp_rd[n]}, {27'b0, wb_rd});
            check_value("wb_data", exp_val[n], wb_data);
            commit_count <= commit_count + 1;
            // Credit comes back 0 to 6 cycles later with at most one per cycle
            due = cycle + int'($urandom % 7);
            if (due <= last_due) begin
                due = last_due + 1;
            end
            last_due = due;
            credit_due.push_back(due);
        end
    endtask

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle - run_start_cycle > TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation failed");
            $fatal(1, "Timeout");
        end else begin
            if (wb_valid) begin
                record_commit();
            end
            if (credit_due.size() > 0 && credit_due[0] <= cycle) begin
                wb_credit <= 1'b1;
                void'(credit_due.pop_front());
            end else begin
                wb_credit <= 1'b0;
            end
        end
    end

    // One pass from RESET_PC until the whole commit list has been seen
    task automatic execute_pass();
        commit_base = commit_count;
        run_start_cycle = cycle;
        @(posedge clk);
        run <= 1'b1;
        while (commit_count - commit_base < exp_pc.size()) begin
            @(posedge clk);
        end
        // Self-loop must stay silent
        repeat (IDLE_CYCLES) @(posedge clk);
        run <= 1'b0;
    endtask

    task automatic run_program(input logic predict);
        int a;
        @(posedge clk);
        reset <= 1'b1;
        run <= 1'b0;
        bp_enable <= predict;
        load_en <= 1'b0;
        run_start_cycle = cycle;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        for (a = 0; a < IMEM_DEPTH; a++) begin
            load_en <= 1'b1;
            load_addr <= imem_addr_t'(a);
            load_data <= (a < PROG_LEN) ? prog[a] : fill_word(a);
            @(posedge clk);
        end
        load_en <= 1'b0;
        execute_pass();
    endtask

    initial begin
        reset = 1'b1;
        run = 1'b0;
        bp_enable = 1'b0;
        load_en = 1'b0;
        load_addr = '0;
        load_data = '0;
        void'($urandom(18));
        generate_program();
        build_expected();
        $display("Program of %0d instructions, %0d expected commits",
                 PROG_LEN, exp_pc.size());
        run_program(1'b0);
        run_program(1'b1);
        // Rerun without reset so taken branches meet a trained predictor
        execute_pass();
        if (error_count == 0) begin
            $display("Simulation passed");
            $finish;
        end else begin
            $display("Simulation failed");
            $fatal(1, "Errors found");
        end
    end

endmodule

//--- cpu.f
verilog/isa_pkg.sv
verilog/core_pkg.sv
verilog/alu.sv
verilog/reg_file.sv
verilog/branch_predictor.sv
verilog/fetch_unit.sv
verilog/decode_unit.sv
verilog/execute_unit.sv
verilog/cpu.sv
tb/cpu_sva.sv
tb/tb_cpu.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/100ps --top-module tb_cpu -f cpu.f -o Vtb_cpu
	./obj_dir/Vtb_cpu > sim.log 2>&1 || echo "Simulation failed" >> sim.log
	cat sim.log
	! grep -q "Simulation failed" sim.log

clean:
	rm -rf obj_dir sim.log
